//--- source/fetch_defs.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction fetch parameters
// address width, reset vector, decode credits and the
// read response codes of the fetch bus
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// pc and bus address width
`define FETCH_ADDR_WIDTH 32

// first address fetched after reset
`define FETCH_RESET_PC 32'h8000_0000

// slots decode grants after reset, 1 to 7
`define FETCH_CREDITS 2

// read response codes
`define RESP_OKAY   2'b00
`define RESP_SLVERR 2'b10

`endif

//--- source/rv_isa_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// rv32i instruction set definitions
// opcodes, funct fields and a two-view instruction word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package rv_isa_pkg;

	// major opcodes
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	// funct3 values
	localparam logic [2:0] F3_JALR  = 3'b000;
	localparam logic [2:0] F3_BEQ   = 3'b000;
	localparam logic [2:0] F3_BNE   = 3'b001;
	localparam logic [2:0] F3_BLT   = 3'b100;
	localparam logic [2:0] F3_BGE   = 3'b101;
	localparam logic [2:0] F3_BLTU  = 3'b110;
	localparam logic [2:0] F3_BGEU  = 3'b111;
	localparam logic [2:0] F3_LB    = 3'b000;
	localparam logic [2:0] F3_LH    = 3'b001;
	localparam logic [2:0] F3_LW    = 3'b010;
	localparam logic [2:0] F3_LBU   = 3'b100;
	localparam logic [2:0] F3_LHU   = 3'b101;
	localparam logic [2:0] F3_SB    = 3'b000;
	localparam logic [2:0] F3_SH    = 3'b001;
	localparam logic [2:0] F3_SW    = 3'b010;
	localparam logic [2:0] F3_SLLI  = 3'b001;
	localparam logic [2:0] F3_SRLI  = 3'b101;
	localparam logic [2:0] F3_PRIV  = 3'b000;
	localparam logic [2:0] F3_CSRRW = 3'b001;
	localparam logic [2:0] F3_CSRRS = 3'b010;

	// funct7 for shifts, imm12 for privileged words
	localparam logic [6:0]  F7_BASE    = 7'b0000000;
	localparam logic [6:0]  F7_ALT     = 7'b0100000;
	localparam logic [11:0] IMM_ECALL  = 12'h000;
	localparam logic [11:0] IMM_EBREAK = 12'h001;
	localparam logic [11:0] IMM_MRET   = 12'h302;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} rv_r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} rv_i_fmt_t;

	// one word, seen as r-type or i-type
	typedef union packed {
		rv_r_fmt_t r;
		rv_i_fmt_t i;
	} rv_inst_t;

endpackage

`default_nettype wire

//--- source/fetch_bus_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch bus types
// controller states and the read response field
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package fetch_bus_pkg;

	// address phase, data phase, hand to decode, wait for credit
	typedef enum logic [1:0] {
		ADDR  = 2'd0,
		DATA  = 2'd1,
		ISSUE = 2'd2,
		HOLD  = 2'd3
	} fetch_state_t;

	// read response, codes in fetch_defs.svh
	typedef logic [1:0] bus_resp_t;

endpackage

`default_nettype wire

//--- source/pc_sequencer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// program counter sequencer
// keeps the fetch pc and one pending redirect, picked by
// priority trap > jump > branch, and steps the pc by four
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "fetch_defs.svh"

module pc_sequencer (
	input  logic                         clock,
	input  logic                         reset,
	input  logic                         advance_i,
	input  logic                         trap_redirect_i,
	input  logic [`FETCH_ADDR_WIDTH-1:0] trap_target_i,
	input  logic                         jump_i,
	input  logic [`FETCH_ADDR_WIDTH-1:0] jump_target_i,
	input  logic                         branch_taken_i,
	input  logic [`FETCH_ADDR_WIDTH-1:0] branch_target_i,
	output logic [`FETCH_ADDR_WIDTH-1:0] fetch_pc_o
);

	// pc of the last address transfer
	logic [`FETCH_ADDR_WIDTH-1:0] pc;
	logic [`FETCH_ADDR_WIDTH-1:0] pc_plus_4;
	logic [`FETCH_ADDR_WIDTH-1:0] pend_target;
	logic [`FETCH_ADDR_WIDTH-1:0] new_target;
	// 0 none, 1 branch, 2 jump, 3 trap or reset vector
	logic [1:0]                   pend_prio;
	logic [1:0]                   new_prio;

	assign pc_plus_4 = pc + `FETCH_ADDR_WIDTH'(4);
	assign fetch_pc_o = (pend_prio != 2'd0) ? pend_target : pc_plus_4;

	// strongest redirect of this cycle
	always_comb begin
		new_prio = 2'd0;
		new_target = branch_target_i;
		if (trap_redirect_i) begin
			new_prio = 2'd3;
			new_target = trap_target_i;
		end else if (jump_i) begin
			new_prio = 2'd2;
			new_target = jump_target_i;
		end else if (branch_taken_i) begin
			new_prio = 2'd1;
		end
	end

	// reset vector starts out as the pending target
	always_ff @(posedge clock) begin
		if (reset) begin
			pend_prio <= 2'd3;
			pend_target <= `FETCH_RESET_PC;
		end else if (advance_i) begin
			// a pulse in the transfer cycle waits for the next fetch
			pend_prio <= new_prio;
			pend_target <= new_target;
		end else if (new_prio != 2'd0 && new_prio >= pend_prio) begin
			pend_prio <= new_prio;
			pend_target <= new_target;
		end
	end

	always_ff @(posedge clock) begin
		if (advance_i) begin
			pc <= fetch_pc_o;
		end
	end

endmodule

`default_nettype wire

//--- source/inst_legality.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction legality check
// flags any word outside the implemented rv32i subset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module inst_legality import rv_isa_pkg::*; (
	input  rv_inst_t inst_i,
	output logic     illegal_o
);

	logic legal;
	logic sys_exact;

	// ecall, ebreak and mret carry zero rd and rs1
	assign sys_exact = (inst_i.i.funct3 == F3_PRIV) && (inst_i.i.rd == 5'd0)
		&& (inst_i.i.rs1 == 5'd0)
		&& (inst_i.i.imm == IMM_ECALL || inst_i.i.imm == IMM_EBREAK
			|| inst_i.i.imm == IMM_MRET);

	always_comb begin
		legal = 1'b0;
		case (inst_i.r.opcode)
			OPC_LUI, OPC_AUIPC, OPC_JAL: legal = 1'b1;
			OPC_JALR: legal = (inst_i.i.funct3 == F3_JALR);
			OPC_BRANCH: begin
				case (inst_i.r.funct3)
					F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU: legal = 1'b1;
					default: legal = 1'b0;
				endcase
			end
			OPC_LOAD: begin
				case (inst_i.i.funct3)
					F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU: legal = 1'b1;
					default: legal = 1'b0;
				endcase
			end
			OPC_STORE: begin
				case (inst_i.r.funct3)
					F3_SB, F3_SH, F3_SW: legal = 1'b1;
					default: legal = 1'b0;
				endcase
			end
			OPC_OP_IMM: begin
				// shift amounts sit in rs2, funct7 picks the shift kind
				if (inst_i.r.funct3 == F3_SLLI) begin
					legal = (inst_i.r.funct7 == F7_BASE);
				end else if (inst_i.r.funct3 == F3_SRLI) begin
					legal = (inst_i.r.funct7 == F7_BASE) || (inst_i.r.funct7 == F7_ALT);
				end else begin
					legal = 1'b1;
				end
			end
			OPC_OP: legal = 1'b1;
			OPC_SYSTEM: begin
				legal = (inst_i.i.funct3 == F3_CSRRW) || (inst_i.i.funct3 == F3_CSRRS)
					|| sys_exact;
			end
			default: legal = 1'b0;
		endcase
	end

	assign illegal_o = ~legal;

endmodule

`default_nettype wire

//--- source/fetch_controller.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch controller
// one read at a time over the fetch bus, credit count toward
// decode, registered word, pc and flags for delivery
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "fetch_defs.svh"

module fetch_controller import fetch_bus_pkg::*; import rv_isa_pkg::*; (
	input  logic                         clock,
	input  logic                         reset,
	output logic [`FETCH_ADDR_WIDTH-1:0] ar_addr_o,
	output logic                         ar_valid_o,
	input  logic                         ar_ready_i,
	input  logic [31:0]                  r_data_i,
	input  bus_resp_t                    r_resp_i,
	input  logic                         r_valid_i,
	output logic                         r_ready_o,
	input  logic                         credit_i,
	output logic                         inst_valid_o,
	output logic [31:0]                  inst_o,
	output logic [`FETCH_ADDR_WIDTH-1:0] inst_pc_o,
	output logic                         inst_fault_o,
	output rv_inst_t                     raw_inst_o,
	input  logic                         illegal_i,
	output logic                         inst_illegal_o,
	input  logic                         trap_redirect_i,
	input  logic [`FETCH_ADDR_WIDTH-1:0] trap_target_i,
	input  logic                         jump_i,
	input  logic [`FETCH_ADDR_WIDTH-1:0] jump_target_i,
	input  logic                         branch_taken_i,
	input  logic [`FETCH_ADDR_WIDTH-1:0] branch_target_i
);

	fetch_state_t                 state;
	fetch_state_t                 state_next;
	logic [2:0]                   credit_cnt;
	logic [2:0]                   credit_next;
	logic                         ar_fire;
	logic                         r_fire;
	logic                         resp_ok;
	logic [`FETCH_ADDR_WIDTH-1:0] req_pc;

	assign ar_valid_o = (state == ADDR);
	assign r_ready_o = (state == DATA);
	assign inst_valid_o = (state == ISSUE);
	assign ar_fire = ar_valid_o & ar_ready_i;
	assign r_fire = r_valid_i & r_ready_o;
	assign resp_ok = (r_resp_i == `RESP_OKAY);
	assign raw_inst_o = r_data_i;

	// a credit back in the delivery cycle still counts
	assign credit_next = credit_cnt - {2'b00, inst_valid_o} + {2'b00, credit_i};

	always_comb begin
		state_next = state;
		case (state)
			ADDR: if (ar_fire) state_next = DATA;
			DATA: if (r_fire) state_next = ISSUE;
			ISSUE: state_next = (credit_next != 3'd0) ? ADDR : HOLD;
			// also the state out of reset, credits are full then
			HOLD: if (credit_i || credit_cnt != 3'd0) state_next = ADDR;
			default: state_next = HOLD;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= HOLD;
			credit_cnt <= 3'(`FETCH_CREDITS);
		end else begin
			state <= state_next;
			credit_cnt <= credit_next;
		end
	end

	always_ff @(posedge clock) begin
		if (ar_fire) begin
			req_pc <= ar_addr_o;
		end
		if (r_fire) begin
			inst_o <= r_data_i;
			inst_pc_o <= req_pc;
			inst_fault_o <= ~resp_ok;
			// bad response means the word is not decoded
			inst_illegal_o <= illegal_i & resp_ok;
		end
	end

	pc_sequencer pc_sequencer_inst (
		.clock           (clock),
		.reset           (reset),
		.advance_i       (ar_fire),
		.trap_redirect_i (trap_redirect_i),
		.trap_target_i   (trap_target_i),
		.jump_i          (jump_i),
		.jump_target_i   (jump_target_i),
		.branch_taken_i  (branch_taken_i),
		.branch_target_i (branch_target_i),
		.fetch_pc_o      (ar_addr_o)
	);

endmodule

`default_nettype wire

//--- source/inst_fetch_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction fetch stage
// fetch controller with its legality check beside it
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "fetch_defs.svh"

module inst_fetch_top import fetch_bus_pkg::*; import rv_isa_pkg::*; (
	input  logic                         clock,
	input  logic                         reset,
	output logic [`FETCH_ADDR_WIDTH-1:0] ar_addr_o,
	output logic                         ar_valid_o,
	input  logic                         ar_ready_i,
	input  logic [31:0]                  r_data_i,
	input  bus_resp_t                    r_resp_i,
	input  logic                         r_valid_i,
	output logic                         r_ready_o,
	input  logic                         credit_i,
	output logic                         inst_valid_o,
	output logic [31:0]                  inst_o,
	output logic [`FETCH_ADDR_WIDTH-1:0] inst_pc_o,
	output logic                         inst_fault_o,
	output logic                         inst_illegal_o,
	input  logic                         trap_redirect_i,
	input  logic [`FETCH_ADDR_WIDTH-1:0] trap_target_i,
	input  logic                         jump_i,
	input  logic [`FETCH_ADDR_WIDTH-1:0] jump_target_i,
	input  logic                         branch_taken_i,
	input  logic [`FETCH_ADDR_WIDTH-1:0] branch_target_i
);

	// word at the data transfer and its check result
	rv_inst_t raw_inst;
	logic     raw_illegal;

	fetch_controller fetch_controller_inst (
		.clock           (clock),
		.reset           (reset),
		.ar_addr_o       (ar_addr_o),
		.ar_valid_o      (ar_valid_o),
		.ar_ready_i      (ar_ready_i),
		.r_data_i        (r_data_i),
		.r_resp_i        (r_resp_i),
		.r_valid_i       (r_valid_i),
		.r_ready_o       (r_ready_o),
		.credit_i        (credit_i),
		.inst_valid_o    (inst_valid_o),
		.inst_o          (inst_o),
		.inst_pc_o       (inst_pc_o),
		.inst_fault_o    (inst_fault_o),
		.raw_inst_o      (raw_inst),
		.illegal_i       (raw_illegal),
		.inst_illegal_o  (inst_illegal_o),
		.trap_redirect_i (trap_redirect_i),
		.trap_target_i   (trap_target_i),
		.jump_i          (jump_i),
		.jump_target_i   (jump_target_i),
		.branch_taken_i  (branch_taken_i),
		.branch_target_i (branch_target_i)
	);

	inst_legality inst_legality_inst (
		.inst_i    (raw_inst),
		.illegal_o (raw_illegal)
	);

endmodule

`default_nettype wire

//--- bench/fetch_sva.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch bus and credit assertions
// bound into the fetch controller, counts each rule's failures
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "fetch_defs.svh"

module fetch_sva (
	input logic                         clock,
	input logic                         reset,
	input logic                         ar_valid_i,
	input logic                         ar_ready_i,
	input logic [`FETCH_ADDR_WIDTH-1:0] ar_addr_i,
	input logic                         inst_valid_i,
	input logic [2:0]                   credit_cnt_i
);

	int stable_errors = 0;
	int pulse_errors = 0;
	int credit_errors = 0;

	// request and address held until accepted
	addr_hold: assert property (@(posedge clock) disable iff (reset)
		ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_addr_i))
	else begin
		stable_errors++;
		$error("address request changed before ar_ready");
	end

	// one cycle per delivered word
	issue_pulse: assert property (@(posedge clock) disable iff (reset)
		inst_valid_i |=> !inst_valid_i)
	else begin
		pulse_errors++;
		$error("inst_valid held longer than one cycle");
	end

	// each delivery needs a credit in hand
	issue_credit: assert property (@(posedge clock) disable iff (reset)
		inst_valid_i |-> credit_cnt_i != 3'd0)
	else begin
		credit_errors++;
		$error("inst_valid raised with no credit held");
	end

endmodule

bind fetch_controller fetch_sva fetch_sva_inst (
	.clock        (clock),
	.reset        (reset),
	.ar_valid_i   (ar_valid_o),
	.ar_ready_i   (ar_ready_i),
	.ar_addr_i    (ar_addr_o),
	.inst_valid_i (inst_valid_o),
	.credit_cnt_i (credit_cnt)
);

`default_nettype wire

//--- bench/fetch_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction fetch testbench
// memory responder with random latency, credit-returning decode
// model, redirects under back-pressure, reference checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "fetch_defs.svh"

module fetch_tb import rv_isa_pkg::*; import fetch_bus_pkg::*; ();

	localparam int SEED = 7245;

	int seed = SEED;
	logic clock = 1'b0;
	logic reset;
	logic [`FETCH_ADDR_WIDTH-1:0] ar_addr;
	logic ar_valid;
	logic ar_ready;
	logic [31:0] r_data;
	bus_resp_t r_resp;
	logic r_valid;
	logic r_ready;
	logic credit;
	logic inst_valid;
	logic [31:0] inst_word;
	logic [`FETCH_ADDR_WIDTH-1:0] inst_pc;
	logic inst_fault;
	logic inst_illegal;
	logic trap_redirect;
	logic [`FETCH_ADDR_WIDTH-1:0] trap_target;
	logic jump;
	logic [`FETCH_ADDR_WIDTH-1:0] jump_target;
	logic branch_taken;
	logic [`FETCH_ADDR_WIDTH-1:0] branch_target;

	// scoreboard state
	int delivered = 0;
	int returned = 0;
	int credits_sent = 0;
	int reads = 0;
	logic fault_log [int];
	logic withhold = 1'b0;
	logic [1:0] pend_prio = 2'd0;
	logic [`FETCH_ADDR_WIDTH-1:0] pend_target = '0;
	int pend_for = -1;
	logic [`FETCH_ADDR_WIDTH-1:0] last_pc = '0;
	logic [`FETCH_ADDR_WIDTH-1:0] want_pc;
	rv_inst_t want_word;
	logic want_fault;
	logic [1:0] use_prio;

	inst_fetch_top inst_fetch_top_inst (
		.clock           (clock),
		.reset           (reset),
		.ar_addr_o       (ar_addr),
		.ar_valid_o      (ar_valid),
		.ar_ready_i      (ar_ready),
		.r_data_i        (r_data),
		.r_resp_i        (r_resp),
		.r_valid_i       (r_valid),
		.r_ready_o       (r_ready),
		.credit_i        (credit),
		.inst_valid_o    (inst_valid),
		.inst_o          (inst_word),
		.inst_pc_o       (inst_pc),
		.inst_fault_o    (inst_fault),
		.inst_illegal_o  (inst_illegal),
		.trap_redirect_i (trap_redirect),
		.trap_target_i   (trap_target),
		.jump_i          (jump),
		.jump_target_i   (jump_target),
		.branch_taken_i  (branch_taken),
		.branch_target_i (branch_target)
	);

	always #20 clock = ~clock;

	// memory contents, mostly real opcodes with random fields
	function automatic logic [31:0] mem_word(input logic [31:0] addr);
		logic [31:0] h;
		logic [11:0] sys_imm;
		h = (addr ^ 32'(SEED)) * 32'h9E37_79B1;
		h = h ^ (h >> 13) ^ (h << 7);
		case (h[10:8])
			3'd0: h[6:0] = OPC_OP_IMM;
			3'd1: h[6:0] = OPC_LOAD;
			3'd2: h[6:0] = OPC_BRANCH;
			3'd3: h[6:0] = OPC_STORE;
			3'd4: begin
				h[6:0] = OPC_SYSTEM;
				// now and then an exact privileged word, sret among them
				if (h[13:11] == 3'd0) begin
					case (h[15:14])
						2'd0: sys_imm = 12'h000;
						2'd1: sys_imm = 12'h001;
						2'd2: sys_imm = 12'h302;
						default: sys_imm = 12'h102;
					endcase
					h = {sys_imm, 13'd0, OPC_SYSTEM};
				end
			end
			3'd5: h[6:0] = OPC_JALR;
			3'd6: h[6:0] = OPC_OP;
			default: h = h;
		endcase
		return h;
	endfunction

	function automatic logic expect_legal(input logic [31:0] w);
		logic [2:0] f3;
		logic [6:0] f7;
		logic ok;
		f3 = w[14:12];
		f7 = w[31:25];
		case (w[6:0])
			OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_OP: ok = 1'b1;
			OPC_JALR: ok = (f3 == 3'd0);
			OPC_BRANCH: ok = (f3 != 3'd2) && (f3 != 3'd3);
			OPC_LOAD: ok = (f3 != 3'd3) && (f3 != 3'd6) && (f3 != 3'd7);
			OPC_STORE: ok = (f3 <= 3'd2);
			OPC_OP_IMM: begin
				if (f3 == 3'd1)
					ok = (f7 == 7'd0);
				else if (f3 == 3'd5)
					ok = (f7 == 7'd0) || (f7 == 7'b0100000);
				else
					ok = 1'b1;
			end
			OPC_SYSTEM: ok = (f3 == 3'd1) || (f3 == 3'd2) || (w == 32'h0000_0073)
				|| (w == 32'h0010_0073) || (w == 32'h3020_0073);
			default: ok = 1'b0;
		endcase
		return ok;
	endfunction

	function automatic logic [31:0] next_pc(input logic [31:0] last, input logic [1:0] prio,
		input logic [31:0] target);
		return (prio != 2'd0) ? target : last + 32'd4;
	endfunction

	function automatic int assertion_failures();
		return inst_fetch_top_inst.fetch_controller_inst.fetch_sva_inst.stable_errors
			+ inst_fetch_top_inst.fetch_controller_inst.fetch_sva_inst.pulse_errors
			+ inst_fetch_top_inst.fetch_controller_inst.fetch_sva_inst.credit_errors;
	endfunction

	task automatic fail_run(input string why);
		$display("%s (at %0t ns)", why, $time);
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	task automatic check_inst(input rv_inst_t got, input rv_inst_t want, input string what);
		if (got !== want) begin
			$display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, want);
			fail_run("delivered word is wrong");
		end
	endtask

	task automatic check_pc(input logic [`FETCH_ADDR_WIDTH-1:0] got,
		input logic [`FETCH_ADDR_WIDTH-1:0] want, input string what);
		if (got !== want) begin
			$display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, want);
			fail_run("delivered pc is wrong");
		end
	endtask

	task automatic check_flag(input logic got, input logic want, input string what);
		if (got !== want) begin
			$display("Mismatch at %0t ns: %s got %b expected %b", $time, what, got, want);
			fail_run("delivered flag is wrong");
		end
	endtask

	// one redirect cycle, any mix of the three kinds
	task automatic send_redirect();
		int kinds;
		logic [1:0] prio;
		logic [31:0] target;
		#1;
		kinds = $random(seed) & 7;
		if (kinds == 0)
			kinds = 1;
		trap_redirect = kinds[2];
		jump = kinds[1];
		branch_taken = kinds[0];
		trap_target = `FETCH_RESET_PC + ($random(seed) & 32'h0000_fffc);
		jump_target = `FETCH_RESET_PC + ($random(seed) & 32'h0000_fffc);
		branch_target = `FETCH_RESET_PC + ($random(seed) & 32'h0000_fffc);
		if (kinds[2]) begin
			prio = 2'd3;
			target = trap_target;
		end else if (kinds[1]) begin
			prio = 2'd2;
			target = jump_target;
		end else begin
			prio = 2'd1;
			target = branch_target;
		end
		if (prio >= pend_prio) begin
			pend_prio = prio;
			pend_target = target;
		end
		@(posedge clock);
		#2;
		trap_redirect = 1'b0;
		jump = 1'b0;
		branch_taken = 1'b0;
	endtask

	// bus slave, one read at a time
	initial begin
		int waited;
		int delay;
		logic [31:0] addr;
		ar_ready = 1'b0;
		r_valid = 1'b0;
		r_data = 32'd0;
		r_resp = `RESP_OKAY;
		forever begin
			waited = 0;
			@(negedge clock);
			while (!ar_valid) begin
				if (waited == 200)
					fail_run("no address request within 200 cycles");
				waited++;
				@(negedge clock);
			end
			delay = $random(seed) & 3;
			@(posedge clock);
			#2;
			repeat (delay) begin
				@(posedge clock);
				#2;
			end
			ar_ready = 1'b1;
			@(negedge clock);
			if (!ar_valid)
				fail_run("address request dropped before it was accepted");
			addr = ar_addr;
			@(posedge clock);
			#2;
			ar_ready = 1'b0;
			delay = $random(seed) & 3;
			repeat (delay) begin
				@(posedge clock);
				#2;
			end
			r_valid = 1'b1;
			r_data = mem_word(addr);
			r_resp = (($random(seed) & 7) == 0) ? `RESP_SLVERR : `RESP_OKAY;
			fault_log[reads] = (r_resp != `RESP_OKAY);
			reads++;
			waited = 0;
			@(negedge clock);
			while (!r_ready) begin
				if (waited == 200)
					fail_run("read data never accepted within 200 cycles");
				waited++;
				@(negedge clock);
			end
			@(posedge clock);
			#2;
			r_valid = 1'b0;
		end
	end

	// decode side, gives a credit back a few cycles after each word
	initial begin
		int gap;
		gap = 0;
		credit = 1'b0;
		forever begin
			@(posedge clock);
			#2;
			credit = 1'b0;
			if (gap > 0) begin
				gap--;
			end else if (!withhold && delivered > credits_sent) begin
				credit = 1'b1;
				credits_sent++;
				gap = $random(seed) & 3;
			end
		end
	end

	// compare every delivery against the reference model
	always @(negedge clock) begin
		if (!reset) begin
			if (inst_valid) begin
				if (delivered + 1 > `FETCH_CREDITS + returned)
					fail_run("decode received a word without a credit");
				if (!fault_log.exists(delivered))
					fail_run("word delivered without a bus read");
				want_fault = fault_log[delivered];
				use_prio = (pend_for == delivered) ? pend_prio : 2'd0;
				want_pc = (delivered == 0) ? `FETCH_RESET_PC
					: next_pc(last_pc, use_prio, pend_target);
				want_word = mem_word(want_pc);
				check_pc(inst_pc, want_pc, "delivered pc");
				check_inst(inst_word, want_word, "delivered word");
				check_flag(inst_fault, want_fault, "fault flag");
				check_flag(inst_illegal, want_fault ? 1'b0 : ~expect_legal(want_word),
					"illegal flag");
				last_pc = want_pc;
				delivered++;
			end
			if (credit)
				returned++;
			if (assertion_failures() != 0)
				fail_run("a bus or credit assertion failed");
		end
	end

	initial begin
		int waited;
		int prev;
		int target_count;
		int pulses;
		int gap;
		reset = 1'b1;
		trap_redirect = 1'b0;
		trap_target = '0;
		jump = 1'b0;
		jump_target = '0;
		branch_taken = 1'b0;
		branch_target = '0;
		repeat (10) @(posedge clock);
		#2;
		reset = 1'b0;
		while (delivered < 300) begin
			// free running stretch
			target_count = delivered + 16 + ($random(seed) & 15);
			waited = 0;
			prev = delivered;
			while (delivered < target_count) begin
				if (waited == 200)
					fail_run("no delivery for 200 cycles");
				@(posedge clock);
				#1;
				if (delivered == prev) begin
					waited++;
				end else begin
					waited = 0;
					prev = delivered;
				end
			end
			// withhold credits until decode is full
			withhold = 1'b1;
			waited = 0;
			while (delivered - returned < `FETCH_CREDITS) begin
				if (waited == 200)
					fail_run("deliveries did not reach the credit limit");
				waited++;
				@(posedge clock);
				#1;
			end
			repeat (10) begin
				@(posedge clock);
				#1;
				// no credit left, so no new address phase
				if (ar_valid)
					fail_run("address phase started with no credit left");
			end
			pend_prio = 2'd0;
			pend_for = delivered;
			pulses = $random(seed) & 3;
			repeat (pulses) begin
				send_redirect();
				gap = $random(seed) & 3;
				repeat (gap) @(posedge clock);
				@(posedge clock);
				#1;
			end
			@(posedge clock);
			#1;
			withhold = 1'b0;
		end
		if (assertion_failures() == 0) begin
			$display("NO ERRORS");
			$finish;
		end else begin
			fail_run("a bus or credit assertion failed");
		end
	end

endmodule

`default_nettype wire

//--- project.f
+incdir+source
source/rv_isa_pkg.sv
source/fetch_bus_pkg.sv
source/pc_sequencer.sv
source/inst_legality.sv
source/fetch_controller.sv
source/inst_fetch_top.sv
bench/fetch_sva.sv
bench/fetch_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert --top-module fetch_tb -f project.f -o fetch_sim
output=$(./obj_dir/fetch_sim +verilator+error+limit+1000 2>&1 || true)
printf '%s\n' "$output"
if printf '%s\n' "$output" | grep -qx "NO ERRORS"; then
	echo "simulation passed"
	exit 0
fi
echo "simulation failed"
exit 1
